/* common/rvPkg.sv */
package rvPkg;

    localparam int XLEN      = 32;
    localparam int MEM_WORDS = 1024;
    localparam int MEM_AW    = $clog2(MEM_WORDS); // Word index width

    // Major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD  = 3'b000; // Also SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101; // Also SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_SW   = 3'b010;
    localparam logic [2:0] F3_JALR = 3'b000;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA, SRAI

    localparam logic [3:0] ALU_ADD  = 4'b0000;
    localparam logic [3:0] ALU_SUB  = 4'b0001;
    localparam logic [3:0] ALU_AND  = 4'b0010;
    localparam logic [3:0] ALU_OR   = 4'b0011;
    localparam logic [3:0] ALU_SLL  = 4'b0100;
    localparam logic [3:0] ALU_SRL  = 4'b0101;
    localparam logic [3:0] ALU_SRA  = 4'b0110;
    localparam logic [3:0] ALU_SLT  = 4'b0111;
    localparam logic [3:0] ALU_GE   = 4'b1000;
    localparam logic [3:0] ALU_SLTU = 4'b1001;
    localparam logic [3:0] ALU_GEU  = 4'b1010;
    localparam logic [3:0] ALU_NE   = 4'b1011;
    localparam logic [3:0] ALU_EQ   = 4'b1100;
    localparam logic [3:0] ALU_XOR  = 4'b1101;

    // Core sequencer states
    localparam logic [1:0] ST_FETCH = 2'd0;
    localparam logic [1:0] ST_EXEC  = 2'd1;
    localparam logic [1:0] ST_MEM   = 2'd2;
    localparam logic [1:0] ST_HALT  = 2'd3;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic       imm12;
            logic [5:0] immHi; // imm[10:5]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] immLo; // imm[4:1]
            logic       imm11;
            logic [6:0] opcode;
        } bType;
        struct packed {
            logic       imm20;
            logic [9:0] immLo; // imm[10:1]
            logic       imm11;
            logic [7:0] immHi; // imm[19:12]
            logic [4:0] rd;
            logic [6:0] opcode;
        } jType;
    } instrU;

endpackage

/* common/wbBus.sv */
`timescale 1ns/10ps

interface wbBus;
    import rvPkg::*;

    logic            cyc;
    logic            stb;
    logic            we;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] datW;
    logic [XLEN-1:0] datR;
    logic            ack;

    modport master (
        output cyc, stb, we, adr, datW,
        input  datR, ack
    );

    modport slave (
        input  cyc, stb, we, adr, datW,
        output datR, ack
    );

endinterface

/* core/controlDecoder.sv */
`timescale 1ns/10ps

module controlDecoder (
    input  rvPkg::instrU           instr,
    output logic                   regWrite,
    output logic                   memWrite,
    output logic                   memRead,
    output logic                   aluSrcImm,
    output logic                   isBranch,
    output logic                   isJal,
    output logic                   isJalr,
    output logic                   illegal,
    output logic [3:0]             aluOp,
    output logic [rvPkg::XLEN-1:0] imm
);
    import rvPkg::*;

    logic [6:0]      opcode;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [XLEN-1:0] immI, immS, immB, immJ;

    function automatic logic [3:0] arithOp(input logic [2:0] fn, input logic alt);
        case (fn)
            F3_ADD:  arithOp = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  arithOp = ALU_SLL;
            F3_SLT:  arithOp = ALU_SLT;
            F3_SLTU: arithOp = ALU_SLTU;
            F3_XOR:  arithOp = ALU_XOR;
            F3_SRL:  arithOp = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   arithOp = ALU_OR;
            default: arithOp = ALU_AND;
        endcase
    endfunction

    assign opcode = instr.rType.opcode;
    assign f3     = instr.rType.funct3;
    assign f7     = instr.rType.funct7;

    assign immI = {{20{instr.iType.imm[11]}}, instr.iType.imm};
    assign immS = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
    assign immB = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
                   instr.bType.immHi, instr.bType.immLo, 1'b0};
    assign immJ = {{11{instr.jType.imm20}}, instr.jType.imm20, instr.jType.immHi,
                   instr.jType.imm11, instr.jType.immLo, 1'b0};

    always_comb begin
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        memRead   = 1'b0;
        aluSrcImm = 1'b0;
        isBranch  = 1'b0;
        isJal     = 1'b0;
        isJalr    = 1'b0;
        illegal   = 1'b1;
        aluOp     = ALU_ADD;
        imm       = immI;
        case (opcode)
            OP_REG: begin
                if (f7 == F7_BASE || (f7 == F7_ALT && (f3 == F3_ADD || f3 == F3_SRL))) begin
                    illegal  = 1'b0;
                    regWrite = 1'b1;
                    aluOp    = arithOp(f3, f7 == F7_ALT);
                end
            end
            OP_IMM: begin
                // Shift amounts carry funct7 in the upper immediate bits
                if ((f3 != F3_SLL && f3 != F3_SRL) || f7 == F7_BASE ||
                    (f3 == F3_SRL && f7 == F7_ALT)) begin
                    illegal   = 1'b0;
                    regWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                    aluOp     = arithOp(f3, f3 == F3_SRL && f7 == F7_ALT);
                end
            end
            OP_LOAD: begin
                if (f3 == F3_LW) begin
                    illegal   = 1'b0;
                    regWrite  = 1'b1;
                    memRead   = 1'b1;
                    aluSrcImm = 1'b1;
                end
            end
            OP_STORE: begin
                if (f3 == F3_SW) begin
                    illegal   = 1'b0;
                    memWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                    imm       = immS;
                end
            end
            OP_JAL: begin
                illegal  = 1'b0;
                regWrite = 1'b1;
                isJal    = 1'b1;
                imm      = immJ;
            end
            OP_JALR: begin
                if (f3 == F3_JALR) begin
                    illegal   = 1'b0;
                    regWrite  = 1'b1;
                    isJalr    = 1'b1;
                    aluSrcImm = 1'b1;
                end
            end
            OP_BRANCH: begin
                imm      = immB;
                illegal  = 1'b0;
                isBranch = 1'b1;
                case (f3)
                    F3_BEQ:  aluOp = ALU_EQ;
                    F3_BNE:  aluOp = ALU_NE;
                    F3_BLT:  aluOp = ALU_SLT;
                    F3_BGE:  aluOp = ALU_GE;
                    F3_BLTU: aluOp = ALU_SLTU;
                    F3_BGEU: aluOp = ALU_GEU;
                    default: begin
                        illegal  = 1'b1;
                        isBranch = 1'b0;
                    end
                endcase
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

/* core/aluUnit.sv */
`timescale 1ns/10ps

module aluUnit (
    input  logic [3:0]             aluOp,
    input  logic [rvPkg::XLEN-1:0] a,
    input  logic [rvPkg::XLEN-1:0] b,
    output logic [rvPkg::XLEN-1:0] result,
    output logic                   cond
);
    import rvPkg::*;

    logic       lt;
    logic       ltu;
    logic [4:0] shamt;

    assign lt    = $signed(a) < $signed(b);
    assign ltu   = a < b;
    assign shamt = b[4:0];

    always_comb begin
        cond = 1'b0;
        case (aluOp)
            ALU_EQ:   cond = (a == b);
            ALU_NE:   cond = (a != b);
            ALU_SLT:  cond = lt;
            ALU_SLTU: cond = ltu;
            ALU_GE:   cond = !lt;
            ALU_GEU:  cond = !ltu;
            default:  cond = 1'b0;
        endcase
    end

    always_comb begin
        case (aluOp)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;
            ALU_SRA: result = $signed(a) >>> shamt;
            default: result = {{(XLEN-1){1'b0}}, cond}; // Set-less-than and compares
        endcase
    end

endmodule

/* core/regFile.sv */
`timescale 1ns/10ps

module regFile (
    input  logic                   rstn,
    input  logic                   rstN,
    input  logic [4:0]             rs1Addr,
    input  logic [4:0]             rs2Addr,
    input  logic [4:0]             rdAddr,
    input  logic                   rdWe,
    input  logic [rvPkg::XLEN-1:0] rdData,
    output logic [rvPkg::XLEN-1:0] rs1Data,
    output logic [rvPkg::XLEN-1:0] rs2Data
);
    import rvPkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge rstn) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWe && rdAddr != 5'd0) begin // x0 stays zero
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

endmodule

/* core/rvCore.sv */
`timescale 1ns/10ps

module rvCore (
    input  logic                   rstn,
    input  logic                   rstN,
    wbBus.master                   bus,
    output logic                   retireValid,
    output logic                   retireWe,
    output logic                   halted,
    output logic [rvPkg::XLEN-1:0] retirePc,
    output logic [rvPkg::XLEN-1:0] retireData,
    output logic [4:0]             retireRd
);
    import rvPkg::*;

    logic [1:0]      state;
    logic [XLEN-1:0] pc, pcPlus4, branchTarget, nextPc;
    instrU           ir;
    logic            regWrite, memWrite, memRead, aluSrcImm;
    logic            isBranch, isJal, isJalr, illegal;
    logic [3:0]      aluOp;
    logic [XLEN-1:0] imm, rs1Data, rs2Data, aluB, aluResult, rfData;
    logic            cond;
    logic            execRetire, memDone, retire, rfWe;
    logic            launch, launchWe;
    logic [XLEN-1:0] launchAdr;
    logic [4:0]      rdAddr;

    controlDecoder uDecoder (
        .instr(ir), .regWrite(regWrite), .memWrite(memWrite), .memRead(memRead),
        .aluSrcImm(aluSrcImm), .isBranch(isBranch), .isJal(isJal), .isJalr(isJalr),
        .illegal(illegal), .aluOp(aluOp), .imm(imm)
    );

    aluUnit uAlu (.aluOp(aluOp), .a(rs1Data), .b(aluB), .result(aluResult), .cond(cond));

    regFile uRegs (
        .rstn(rstn), .rstN(rstN), .rs1Addr(ir.rType.rs1), .rs2Addr(ir.rType.rs2),
        .rdAddr(rdAddr), .rdWe(rfWe), .rdData(rfData), .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    assign rdAddr       = ir.rType.rd;
    assign aluB         = aluSrcImm ? imm : rs2Data;
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pc + imm; // Also the JAL target

    always_comb begin
        if (isJal) begin
            nextPc = branchTarget;
        end else if (isJalr) begin
            nextPc = {aluResult[XLEN-1:1], 1'b0};
        end else if (isBranch && cond) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    assign execRetire = (state == ST_EXEC) && !illegal && !memRead && !memWrite;
    assign memDone    = (state == ST_MEM) && bus.ack;
    assign retire     = execRetire || memDone;
    assign rfWe       = retire && regWrite;

    always_comb begin
        if (memRead) begin
            rfData = bus.datR;
        end else if (isJal || isJalr) begin
            rfData = pcPlus4; // Link address
        end else begin
            rfData = aluResult;
        end
    end

    // Next bus cycle to start for fetch or data
    always_comb begin
        launch    = 1'b0;
        launchWe  = 1'b0;
        launchAdr = pc;
        if (state == ST_FETCH && !bus.cyc) begin
            launch = 1'b1;
        end else if (state == ST_EXEC && !illegal) begin
            launch = 1'b1;
            if (memRead || memWrite) begin
                launchAdr = aluResult;
                launchWe  = memWrite;
            end else begin
                launchAdr = nextPc;
            end
        end
    end

    always_ff @(posedge rstn) begin
        if (!rstN) begin
            state       <= ST_FETCH;
            pc          <= '0;
            bus.cyc     <= 1'b0;
            bus.stb     <= 1'b0;
            bus.we      <= 1'b0;
            retireValid <= 1'b0;
        end else begin
            retireValid <= retire;
            if (launch) begin
                bus.cyc <= 1'b1;
                bus.stb <= 1'b1;
                bus.we  <= launchWe;
            end else if (bus.ack) begin
                bus.cyc <= 1'b0;
                bus.stb <= 1'b0;
                bus.we  <= 1'b0;
            end
            case (state)
                ST_FETCH: if (bus.ack) state <= ST_EXEC;
                ST_EXEC: begin
                    if (illegal) begin
                        state <= ST_HALT;
                    end else if (memRead || memWrite) begin
                        state <= ST_MEM;
                    end else begin
                        state <= ST_FETCH;
                        pc    <= nextPc;
                    end
                end
                ST_MEM: begin
                    if (bus.ack) begin
                        state <= ST_FETCH;
                        pc    <= nextPc;
                    end
                end
                default: state <= ST_HALT;
            endcase
        end
    end

    always_ff @(posedge rstn) begin
        if (launch) begin
            bus.adr  <= launchAdr;
            bus.datW <= rs2Data; // Only used by stores
        end
        if (state == ST_FETCH && bus.ack) begin
            ir <= bus.datR;
        end
        if (retire) begin
            retirePc   <= pc;
            retireRd   <= regWrite ? rdAddr : 5'd0;
            retireWe   <= rfWe && rdAddr != 5'd0;
            retireData <= memWrite ? rs2Data : rfData;
        end
    end

    assign halted = (state == ST_HALT);

    reqHeld: assert property (@(posedge rstn) disable iff (!rstN)
        bus.stb && !bus.ack |=> bus.stb && $stable(bus.adr) && $stable(bus.we));

    haltSticky: assert property (@(posedge rstn) disable iff (!rstN)
        state == ST_HALT |=> state == ST_HALT && !bus.stb);

endmodule

/* hdl/wbSram.sv */
`timescale 1ns/10ps

module wbSram (
    input  logic                   rstn,
    input  logic                   rstN,
    wbBus.slave                    bus,
    input  logic                   loadWe,
    input  logic [rvPkg::XLEN-1:0] loadAddr,
    input  logic [rvPkg::XLEN-1:0] loadData
);
    import rvPkg::*;

    logic [XLEN-1:0]   mem [MEM_WORDS];
    logic              waitSt; // Wait state before ack
    logic [MEM_AW-1:0] busIdx;
    logic [MEM_AW-1:0] loadIdx;

    assign busIdx  = bus.adr[MEM_AW+1:2];
    assign loadIdx = loadAddr[MEM_AW+1:2];

    always_ff @(posedge rstn) begin
        if (!rstN) begin
            waitSt  <= 1'b0;
            bus.ack <= 1'b0;
        end else begin
            waitSt  <= bus.cyc && bus.stb && !waitSt && !bus.ack; // Gap after each ack
            bus.ack <= waitSt;
        end
    end

    always_ff @(posedge rstn) begin
        if (loadWe) begin
            mem[loadIdx] <= loadData;
        end else if (bus.ack && bus.we) begin
            mem[busIdx] <= bus.datW;
        end
        if (waitSt) begin
            bus.datR <= mem[busIdx];
        end
    end

    // Master must hold the request through the acknowledged cycle
    ackInCycle: assert property (@(posedge rstn) disable iff (!rstN)
        bus.ack |-> bus.cyc && bus.stb);

endmodule

/* hdl/rvSystem.sv */
`timescale 1ns/10ps

module rvSystem (
    input  logic                   rstn,
    input  logic                   rstN,
    input  logic                   loadWe,
    input  logic [rvPkg::XLEN-1:0] loadAddr,
    input  logic [rvPkg::XLEN-1:0] loadData,
    output logic                   retireValid,
    output logic [rvPkg::XLEN-1:0] retirePc,
    output logic [4:0]             retireRd,
    output logic                   retireWe,
    output logic [rvPkg::XLEN-1:0] retireData,
    output logic                   halted
);

    wbBus bus ();

    rvCore uCore (
        .rstn(rstn),
        .rstN(rstN),
        .bus(bus.master),
        .retireValid(retireValid),
        .retireWe(retireWe),
        .halted(halted),
        .retirePc(retirePc),
        .retireData(retireData),
        .retireRd(retireRd)
    );

    wbSram uMem (
        .rstn(rstn),
        .rstN(rstN),
        .bus(bus.slave),
        .loadWe(loadWe),
        .loadAddr(loadAddr),
        .loadData(loadData)
    );

endmodule

/* tests/refModel.svh */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

logic [31:0] refRegs [32];
logic [31:0] refMem [MEM_WORDS];
logic [31:0] prog [$];
string       tags [$];

function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
    case (f3)
        F3_ADD:  return alt ? a - b : a + b;
        F3_SLL:  return a << b[4:0];
        F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
        F3_SLTU: return {31'b0, a < b};
        F3_XOR:  return a ^ b;
        F3_SRL: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
        end
        F3_OR:   return a | b;
        default: return a & b;
    endcase
endfunction

// Executes the word at pc and updates the model state
function automatic void refStep(input logic [31:0] pc, output logic ill, output logic [4:0] rd,
                                output logic we, output logic [31:0] data, output logic chk,
                                output logic [31:0] nextPc);
    logic [31:0] w, a, b, iImm, value, addr;
    logic        taken;
    w      = refMem[pc[MEM_AW+1:2]];
    a      = refRegs[w[19:15]];
    b      = refRegs[w[24:20]];
    iImm   = {{20{w[31]}}, w[31:20]};
    ill    = 1'b0;
    rd     = 5'd0;
    we     = 1'b0;
    data   = '0;
    chk    = 1'b0;
    value  = '0;
    taken  = 1'b0;
    nextPc = pc + 32'd4;
    case (w[6:0])
        OP_REG, OP_IMM: begin
            we    = 1'b1;
            value = aluRef(w[14:12], w[30] && (w[6:0] == OP_REG || w[14:12] == F3_SRL),
                           a, (w[6:0] == OP_REG) ? b : iImm);
        end
        OP_LOAD: begin
            we    = 1'b1;
            addr  = a + iImm;
            value = refMem[addr[MEM_AW+1:2]];
        end
        OP_STORE: begin
            addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
            refMem[addr[MEM_AW+1:2]] = b;
            data = b;
            chk  = 1'b1;
        end
        OP_JAL: begin
            we     = 1'b1;
            value  = pc + 32'd4;
            nextPc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        OP_JALR: begin
            we     = 1'b1;
            value  = pc + 32'd4;
            addr   = a + iImm;
            nextPc = {addr[31:1], 1'b0};
        end
        OP_BRANCH: begin
            case (w[14:12])
                F3_BEQ:  taken = (a == b);
                F3_BNE:  taken = (a != b);
                F3_BLT:  taken = ($signed(a) < $signed(b));
                F3_BGE:  taken = ($signed(a) >= $signed(b));
                F3_BLTU: taken = (a < b);
                F3_BGEU: taken = (a >= b);
                default: ill = 1'b1;
            endcase
            if (taken) begin
                nextPc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
        end
        default: ill = 1'b1;
    endcase
    if (we) begin
        rd = w[11:7];
    end
    we = we && rd != 5'd0; // x0 is never written
    if (we) begin
        refRegs[rd] = value;
        data        = value;
        chk         = 1'b1;
    end
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OP_STORE};
endfunction

function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

task automatic emit(input logic [31:0] word, input string tag);
    prog.push_back(word);
    tags.push_back(tag);
endtask

task automatic emitFiller(input string tag);
    emit(encI(12'd1, 5'd21, F3_ADD, 5'd21, OP_IMM), tag); // Skipped when the jump is taken
endtask

task automatic genProgram();
    logic [2:0]  regF3 [10];
    logic        regAlt [10];
    logic [2:0]  immF3 [9];
    logic [2:0]  brF3 [6];
    logic [31:0] r;
    int          base;
    regF3  = '{F3_ADD, F3_ADD, F3_AND, F3_OR, F3_XOR, F3_SLT, F3_SLTU, F3_SLL, F3_SRL, F3_SRL};
    regAlt = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    immF3  = '{F3_ADD, F3_AND, F3_OR, F3_XOR, F3_SLT, F3_SLTU, F3_SLL, F3_SRL, F3_SRL};
    brF3   = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    for (int k = 0; k < 32; k++) begin
        refRegs[k] = '0;
    end
    r = randBits(12);
    emit(encI({1'b1, r[10:0]}, 5'd0, F3_ADD, 5'd1, OP_IMM), "regreg"); // x1 negative
    r = randBits(12);
    emit(encI({1'b0, r[10:0]}, 5'd0, F3_ADD, 5'd2, OP_IMM), "regreg"); // x2 positive
    for (int k = 3; k < 5; k++) begin
        r = randBits(12);
        emit(encI(r[11:0], 5'd0, F3_ADD, 5'(k), OP_IMM), "regreg");
    end
    for (int k = 0; k < 10; k++) begin
        // SUB and SRA take the negative x1
        emit({regAlt[k] ? F7_ALT : F7_BASE, randReg(1, 4),
              regAlt[k] ? 5'd1 : randReg(1, 4), regF3[k], randReg(5, 15), OP_REG}, "regreg");
    end
    for (int k = 0; k < 9; k++) begin
        r = randBits(12);
        if (k >= 6) begin
            r[11:5] = (k == 8) ? F7_ALT : F7_BASE; // SLLI, SRLI, SRAI
        end
        emit(encI(r[11:0], (k == 8) ? 5'd1 : randReg(1, 15), immF3[k], randReg(5, 15),
                  OP_IMM), "immediate");
    end
    for (int k = 0; k < 3; k++) begin
        emit(encS(12'h400 + 12'(4 * k), randReg(1, 15), 5'd0), "memory");
    end
    for (int k = 0; k < 3; k++) begin
        emit(encI(12'h400 + 12'(4 * k), 5'd0, F3_LW, randReg(5, 15), OP_LOAD), "memory");
    end
    for (int k = 0; k < 6; k++) begin
        for (int p = 0; p < 3; p++) begin
            emit(encB(13'd8, (p == 1) ? 5'd2 : 5'd1, (p == 2) ? 5'd2 : 5'd1, brF3[k]), "branch");
            emitFiller("branch");
        end
    end
    emit(encJ(21'd8, randReg(5, 15)), "jump");
    emitFiller("jump");
    emit(encJ(21'd8, 5'd0), "jump");
    emitFiller("jump");
    base = prog.size();
    emit(encI(12'((base + 3) * 4 + 1), 5'd0, F3_ADD, 5'd22, OP_IMM), "jump"); // Odd target
    emit(encI(12'd0, 5'd22, F3_JALR, randReg(16, 19), OP_JALR), "jump");
    emitFiller("jump");
    emit(32'h0000_000B, "halt"); // Custom-0 opcode
endtask

`endif

/* tests/tbCore.sv */
`timescale 1ns/10ps

module tbCore;
    import rvPkg::*;

    logic            rstn;
    logic            rstN;
    logic            loadWe;
    logic [XLEN-1:0] loadAddr;
    logic [XLEN-1:0] loadData;
    logic            retireValid;
    logic [XLEN-1:0] retirePc;
    logic [4:0]      retireRd;
    logic            retireWe;
    logic [XLEN-1:0] retireData;
    logic            halted;

    logic [31:0] lfsr = 32'd32;
    logic [31:0] modelPc = '0;
    logic [31:0] haltPc = '0;
    int          errors = 0;
    int          checks = 0;
    int          limitCycles = 0;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [4:0] randReg(input int lo, input int hi);
        logic [31:0] r;
        r = randBits(5);
        return 5'(lo + r % (hi - lo + 1));
    endfunction

    `include "refModel.svh"

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    rvSystem dut_i (
        .rstn(rstn), .rstN(rstN), .loadWe(loadWe), .loadAddr(loadAddr), .loadData(loadData),
        .retireValid(retireValid), .retirePc(retirePc), .retireRd(retireRd),
        .retireWe(retireWe), .retireData(retireData), .halted(halted)
    );

    initial begin
        rstn = 1'b0;
        forever #2 rstn = ~rstn; // 4 ns period
    end

    initial begin
        wait (limitCycles > 0);
        #(limitCycles * 4);
        $display("Timeout: the core did not halt and go quiet within %0d cycles", limitCycles);
        $display("RESULT: FAIL");
        $finish;
    end

    always @(negedge rstn) begin : compareRetire
        logic        ill, expWe, chk;
        logic [4:0]  expRd;
        logic [31:0] expData, expNext;
        string       tag;
        if (rstN && retireValid) begin
            tag = tags[modelPc[MEM_AW+1:2]];
            refStep(modelPc, ill, expRd, expWe, expData, chk, expNext);
            if (ill) begin
                errors++;
                $display("Core retired pc %h although the next instruction is unsupported",
                         retirePc);
            end else begin
                checkValue({tag, " retirePc"}, modelPc, retirePc);
                checkValue({tag, " retireRd"}, {27'b0, expRd}, {27'b0, retireRd});
                checkValue({tag, " retireWe"}, {31'b0, expWe}, {31'b0, retireWe});
                if (chk) begin
                    checkValue({tag, " retireData"}, expData, retireData);
                end
                modelPc = expNext;
            end
        end
    end

    initial begin
        rstN     = 1'b0;
        loadWe   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        genProgram();
        haltPc      = (prog.size() - 1) * 4;
        limitCycles = 9 * prog.size() + 80; // Load and reset plus 8 per instruction
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge rstn);
            #1;
            loadWe    = 1'b1;
            loadAddr  = i * 4;
            loadData  = prog[i];
            refMem[i] = prog[i];
        end
        @(posedge rstn);
        #1;
        loadWe = 1'b0;
        repeat (8) @(posedge rstn);
        #1;
        rstN = 1'b1;
        while (!halted) begin
            @(negedge rstn);
        end
        repeat (30) @(negedge rstn); // Any retire here is flagged
        checkValue("halt pc", haltPc, modelPc);
        checkValue("halted", 32'd1, {31'b0, halted});
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+tests
common/rvPkg.sv
common/wbBus.sv
core/controlDecoder.sv
core/aluUnit.sv
core/regFile.sv
core/rvCore.sv
hdl/wbSram.sv
hdl/rvSystem.sv
tests/tbCore.sv
